// ==== common/alu_op_pkg.sv ====
package alu_op_pkg;

    localparam int OP_W = 4;

    // codes 4 and 8..15 are accepted and produce 0
    typedef enum logic [OP_W-1:0] {
        OP_FXADD = 4'd0,
        OP_FXSUB = 4'd1,
        OP_FXMUL = 4'd2,
        OP_FXMAC = 4'd3,
        OP_CLZ   = 4'd5,
        OP_LRCW  = 4'd6,
        OP_LFSR  = 4'd7
    } alu_op_e;

    typedef enum logic [1:0] {
        ST_RESET = 2'd0, // busy
        ST_IDLE  = 2'd1, // first cycle out of reset
        ST_EXEC  = 2'd2, // busy
        ST_DONE  = 2'd3  // result valid
    } alu_state_e;

endpackage

// ==== common/alu_fx_pkg.sv ====
package alu_fx_pkg;

    // Q6.10 unless the top level says otherwise
    localparam int INT_W_DEF  = 6;
    localparam int FRAC_W_DEF = 10;

    // tap offsets counted down from the msb
    localparam int unsigned LFSR_TAPS [4] = '{0, 2, 3, 5};

    localparam int unsigned LFSR_MAX_STEPS = 8; // larger step counts give 0

endpackage

// ==== hw/alu_decode.sv ====
module alu_decode
    import alu_op_pkg::*;
#(
    parameter int DATA_W = 16
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic [DATA_W-1:0] i_data_a,
    input  logic [DATA_W-1:0] i_data_b,
    input  logic [OP_W-1:0]   i_inst,
    output logic              o_busy,
    output logic              o_valid,
    output logic              o_exec,
    output alu_op_e           o_op,
    output logic [DATA_W-1:0] o_opa,
    output logic [DATA_W-1:0] o_opb
);

    alu_state_e state;
    alu_state_e state_nxt;

    always_comb begin
        case (state)
            ST_RESET: state_nxt = ST_IDLE;
            ST_IDLE:  state_nxt = ST_EXEC;
            ST_EXEC:  state_nxt = ST_DONE;
            ST_DONE:  state_nxt = ST_EXEC; // one op every two cycles
            default:  state_nxt = ST_EXEC;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= ST_RESET;
        end else begin
            state <= state_nxt;
        end
    end

    assign o_busy  = (state == ST_RESET) || (state == ST_EXEC);
    assign o_valid = (state == ST_DONE);
    assign o_exec  = (state == ST_EXEC);

    // take a new op whenever we are not busy
    always_ff @(posedge i_clk) begin
        if (!o_busy) begin
            o_opa <= i_data_a;
            o_opb <= i_data_b;
            o_op  <= alu_op_e'(i_inst);
        end
    end

endmodule

// ==== execute/alu_fx_arith.sv ====
module alu_fx_arith
    import alu_op_pkg::*;
#(
    parameter int INT_W  = 6,
    parameter int FRAC_W = 10,
    parameter int DATA_W = INT_W + FRAC_W
) (
    input  alu_op_e           i_op,
    input  logic [DATA_W-1:0] i_opa,
    input  logic [DATA_W-1:0] i_opb,
    input  logic [DATA_W-1:0] i_acc,
    output logic [DATA_W-1:0] o_res
);

    localparam int SUM_W = 2 * DATA_W + 1; // product plus shifted accumulator
    localparam int TOP_B = DATA_W + FRAC_W - 1;

    localparam logic [DATA_W-1:0] MAX_POS = {1'b0, {(DATA_W-1){1'b1}}};
    localparam logic [DATA_W-1:0] MIN_NEG = {1'b1, {(DATA_W-1){1'b0}}};

    logic [DATA_W:0]          as_sum;
    logic [DATA_W-1:0]        as_res;
    logic signed [2*DATA_W-1:0] mult;
    logic [SUM_W-1:0]         acc_term;
    logic [SUM_W-1:0]         prod;
    logic                     prod_fits;
    logic [DATA_W-1:0]        trunc;
    logic [DATA_W-1:0]        mul_res;

    // add / sub on one extra bit, clamp when the two top bits disagree
    always_comb begin
        if (i_op == OP_FXSUB) begin
            as_sum = {i_opa[DATA_W-1], i_opa} - {i_opb[DATA_W-1], i_opb};
        end else begin
            as_sum = {i_opa[DATA_W-1], i_opa} + {i_opb[DATA_W-1], i_opb};
        end

        if (as_sum[DATA_W] != as_sum[DATA_W-1]) begin
            as_res = as_sum[DATA_W] ? MIN_NEG : MAX_POS;
        end else begin
            as_res = as_sum[DATA_W-1:0];
        end
    end

    assign mult = $signed(i_opa) * $signed(i_opb);

    // accumulator aligned to the product's binary point
    assign acc_term = (i_op == OP_FXMAC) ?
                      ({{(SUM_W-DATA_W){i_acc[DATA_W-1]}}, i_acc} << FRAC_W) : '0;

    assign prod = {mult[2*DATA_W-1], mult} + acc_term;

    // fits when everything from TOP_B up is a plain sign extension
    assign prod_fits = (&prod[SUM_W-1:TOP_B]) || !(|prod[SUM_W-1:TOP_B]);
    assign trunc     = prod[2*DATA_W-INT_W-1 -: DATA_W];

    always_comb begin
        if (!prod_fits) begin
            mul_res = prod[SUM_W-1] ? MIN_NEG : MAX_POS;
        end else if (prod[FRAC_W-1] && (trunc == MAX_POS)) begin
            mul_res = MAX_POS; // rounding would wrap
        end else begin
            mul_res = trunc + DATA_W'(prod[FRAC_W-1]);
        end
    end

    always_comb begin
        case (i_op)
            OP_FXADD, OP_FXSUB: o_res = as_res;
            OP_FXMUL, OP_FXMAC: o_res = mul_res;
            default:            o_res = '0;
        endcase
    end

endmodule

// ==== execute/alu_bit_ops.sv ====
module alu_bit_ops
    import alu_op_pkg::*;
    import alu_fx_pkg::*;
#(
    parameter int DATA_W = 16
) (
    input  alu_op_e           i_op,
    input  logic [DATA_W-1:0] i_opa,
    input  logic [DATA_W-1:0] i_opb,
    output logic [DATA_W-1:0] o_res
);

    localparam int CNT_W = $clog2(DATA_W + 1);

    logic [DATA_W-1:0] clz_res;
    logic              clz_hit;
    logic [CNT_W-1:0]  pop;
    logic [DATA_W-1:0] lrcw_res;
    logic [DATA_W-1:0] lfsr_res;
    logic [DATA_W-1:0] lfsr_q;

    function automatic logic [DATA_W-1:0] lfsr_step(input logic [DATA_W-1:0] s);
        logic fb;
        fb = 1'b0;
        for (int t = 0; t < $size(LFSR_TAPS); t++) begin
            fb ^= s[DATA_W-1-LFSR_TAPS[t]];
        end
        return {s[DATA_W-2:0], fb};
    endfunction

    // first set bit from the top wins
    always_comb begin
        clz_res = DATA_W'(DATA_W);
        clz_hit = 1'b0;
        for (int i = DATA_W - 1; i >= 0; i--) begin
            if (!clz_hit && i_opa[i]) begin
                clz_res = DATA_W'(DATA_W - 1 - i);
                clz_hit = 1'b1;
            end
        end
    end

    always_comb begin
        pop = '0;
        for (int i = 0; i < DATA_W; i++) begin
            pop = pop + CNT_W'(i_opa[i]);
        end
    end

    // bits shifted out come back inverted at the bottom
    assign lrcw_res = (i_opb << pop)
                    | (~(i_opb >> (DATA_W - pop)) & ~({DATA_W{1'b1}} << pop));

    always_comb begin
        lfsr_q = i_opa;
        for (int k = 1; k <= LFSR_MAX_STEPS; k++) begin
            if (k <= i_opb) begin
                lfsr_q = lfsr_step(lfsr_q);
            end
        end
        lfsr_res = (i_opb > LFSR_MAX_STEPS) ? '0 : lfsr_q;
    end

    always_comb begin
        case (i_op)
            OP_CLZ:  o_res = clz_res;
            OP_LRCW: o_res = lrcw_res;
            OP_LFSR: o_res = lfsr_res;
            default: o_res = '0;
        endcase
    end

endmodule

// ==== hw/alu_result.sv ====
module alu_result
    import alu_op_pkg::*;
#(
    parameter int DATA_W = 16
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_exec,
    input  alu_op_e           i_op,
    input  logic [DATA_W-1:0] i_arith_res,
    input  logic [DATA_W-1:0] i_bit_res,
    output logic [DATA_W-1:0] o_data,
    output logic [DATA_W-1:0] o_acc
);

    logic [DATA_W-1:0] res_sel;
    logic [DATA_W-1:0] res_q;

    always_comb begin
        case (i_op)
            OP_FXADD, OP_FXSUB, OP_FXMUL, OP_FXMAC: res_sel = i_arith_res;
            OP_CLZ, OP_LRCW, OP_LFSR:               res_sel = i_bit_res;
            default:                                res_sel = '0; // dropped or unused opcode
        endcase
    end

    // latched at the end of the exec cycle, held until the next op
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            res_q <= '0;
        end else if (i_exec) begin
            res_q <= res_sel;
        end
    end

    assign o_data = res_q;
    assign o_acc  = res_q; // mac accumulates on the last result of any op

endmodule

// ==== hw/alu_top.sv ====
module alu_top
    import alu_op_pkg::*;
    import alu_fx_pkg::*;
#(
    parameter int INT_W  = INT_W_DEF,
    parameter int FRAC_W = FRAC_W_DEF,
    parameter int DATA_W = INT_W + FRAC_W
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic [DATA_W-1:0] i_data_a,
    input  logic [DATA_W-1:0] i_data_b,
    input  logic [OP_W-1:0]   i_inst,
    output logic              o_busy,
    output logic              o_valid,
    output logic [DATA_W-1:0] o_data
);

    logic              exec;
    alu_op_e           op;
    logic [DATA_W-1:0] opa;
    logic [DATA_W-1:0] opb;
    logic [DATA_W-1:0] acc;
    logic [DATA_W-1:0] arith_res;
    logic [DATA_W-1:0] bit_res;

    alu_decode #(
        .DATA_W (DATA_W)
    ) u_decode (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_data_a (i_data_a),
        .i_data_b (i_data_b),
        .i_inst   (i_inst),
        .o_busy   (o_busy),
        .o_valid  (o_valid),
        .o_exec   (exec),
        .o_op     (op),
        .o_opa    (opa),
        .o_opb    (opb)
    );

    alu_fx_arith #(
        .INT_W  (INT_W),
        .FRAC_W (FRAC_W),
        .DATA_W (DATA_W)
    ) u_fx_arith (
        .i_op  (op),
        .i_opa (opa),
        .i_opb (opb),
        .i_acc (acc),
        .o_res (arith_res)
    );

    alu_bit_ops #(
        .DATA_W (DATA_W)
    ) u_bit_ops (
        .i_op  (op),
        .i_opa (opa),
        .i_opb (opb),
        .o_res (bit_res)
    );

    alu_result #(
        .DATA_W (DATA_W)
    ) u_result (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_exec      (exec),
        .i_op        (op),
        .i_arith_res (arith_res),
        .i_bit_res   (bit_res),
        .o_data      (o_data),
        .o_acc       (acc)
    );

endmodule

// ==== sim/alu_assertions.sv ====
module alu_assertions
    import alu_op_pkg::*;
    import alu_fx_pkg::*;
#(
    parameter int FRAC_W = 10,
    parameter int DATA_W = 16
) (
    input logic              i_clk,
    input logic              i_rst_n,
    input logic [DATA_W-1:0] i_data_a,
    input logic [DATA_W-1:0] i_data_b,
    input logic [OP_W-1:0]   i_inst,
    input logic              o_busy,
    input logic              o_valid,
    input logic [DATA_W-1:0] o_data
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam longint HALF   = longint'(1) << (DATA_W - 1);
    localparam longint PBOUND = longint'(1) << (DATA_W + FRAC_W - 1); // product range

    int                fail_count = 0;
    logic [DATA_W-1:0] cap_a;
    logic [DATA_W-1:0] cap_b;
    logic [OP_W-1:0]   cap_op;
    logic [DATA_W-1:0] acc_m;
    logic [DATA_W-1:0] exp_data;
    longint            sa;
    longint            sb;
    longint            sacc;

    function automatic logic [DATA_W-1:0] clamp(input longint v);
        if (v > HALF - 1) begin
            return DATA_W'(HALF - 1);
        end
        if (v < -HALF) begin
            return DATA_W'(-HALF);
        end
        return DATA_W'(v);
    endfunction

    function automatic logic [DATA_W-1:0] fx_mul(input longint a, input longint b,
                                                 input longint acc);
        longint p;
        p = a * b + acc * (longint'(1) << FRAC_W);
        if (p >= PBOUND || p < -PBOUND) begin
            return clamp(p);
        end
        return clamp((p >>> FRAC_W) + longint'(p[FRAC_W-1])); // round on the first dropped bit
    endfunction

    function automatic logic [DATA_W-1:0] clz(input logic [DATA_W-1:0] a);
        int n;
        n = 0;
        while (n < DATA_W && !a[DATA_W-1-n]) begin
            n++;
        end
        return DATA_W'(n);
    endfunction

    function automatic logic [DATA_W-1:0] lrcw(input logic [DATA_W-1:0] a,
                                               input logic [DATA_W-1:0] b);
        logic [DATA_W-1:0] r;
        int                n;
        n = $countones(a);
        for (int i = 0; i < DATA_W; i++) begin
            r[i] = (i < n) ? ~b[DATA_W-n+i] : b[i-n];
        end
        return r;
    endfunction

    function automatic logic [DATA_W-1:0] lfsr_steps(input logic [DATA_W-1:0] a,
                                                     input logic [DATA_W-1:0] b);
        logic [DATA_W-1:0] s;
        s = a;
        if (b > LFSR_MAX_STEPS) begin
            return '0;
        end
        repeat (b) begin
            s = {s[DATA_W-2:0], s[DATA_W-1] ^ s[DATA_W-3] ^ s[DATA_W-4] ^ s[DATA_W-6]};
        end
        return s;
    endfunction

    always @(posedge i_clk) begin
        if (!o_busy) begin
            cap_a  <= i_data_a;
            cap_b  <= i_data_b;
            cap_op <= i_inst;
        end
    end

    always @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            acc_m <= '0;
        end else if (o_valid) begin
            acc_m <= o_data;
        end
    end

    assign sa   = longint'($signed(cap_a));
    assign sb   = longint'($signed(cap_b));
    assign sacc = longint'($signed(acc_m));

    always_comb begin
        case (cap_op)
            OP_FXADD: exp_data = clamp(sa + sb);
            OP_FXSUB: exp_data = clamp(sa - sb);
            OP_FXMUL: exp_data = fx_mul(sa, sb, 0);
            OP_FXMAC: exp_data = fx_mul(sa, sb, sacc);
            OP_CLZ:   exp_data = clz(cap_a);
            OP_LRCW:  exp_data = lrcw(cap_a, cap_b);
            OP_LFSR:  exp_data = lfsr_steps(cap_a, cap_b);
            default:  exp_data = '0; // dropped and unused codes
        endcase
    end

    a_reset_state: assert property (@(posedge i_clk)
        !i_rst_n |-> (o_busy && !o_valid && o_data == '0)) else begin
        fail_count++;
        $error("Fail reset outputs: o_busy %h o_valid %h o_data %h",
               $sampled(o_busy), $sampled(o_valid), $sampled(o_data));
    end

    a_valid_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_valid == $past(!o_busy, 2)) else begin
        fail_count++;
        $error("o_valid did not come exactly two edges after a capture edge");
    end

    a_valid_not_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_valid |-> !o_busy) else begin
        fail_count++;
        $error("o_valid and o_busy were high in the same cycle");
    end

    a_busy_alternates: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_rst_n |=> (o_busy != $past(o_busy))) else begin
        fail_count++;
        $error("o_busy did not alternate between cycles");
    end

    a_data_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !o_valid |-> $stable(o_data)) else begin
        fail_count++;
        $error("Fail o_data: changed from %h to %h outside a valid cycle",
               $past(o_data), $sampled(o_data));
    end

    a_data: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_valid |-> (o_data == exp_data)) else begin
        fail_count++;
        $error("Fail o_data: got %h expected %h (opcode %h)",
               $sampled(o_data), $sampled(exp_data), $sampled(cap_op));
    end

endmodule

bind alu_top alu_assertions #(
    .FRAC_W (FRAC_W),
    .DATA_W (DATA_W)
) u_assertions (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_data_a (i_data_a),
    .i_data_b (i_data_b),
    .i_inst   (i_inst),
    .o_busy   (o_busy),
    .o_valid  (o_valid),
    .o_data   (o_data)
);

// ==== sim/alu_tb.sv ====
module alu_tb
    import alu_op_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DATA_W   = 16;
    localparam int N_TESTS  = 6;
    localparam int OPS      = 40; // most ops any single test issues
    localparam int RAND_OPS = 20;
    localparam int WATCHDOG = N_TESTS * OPS * 2 + 100;

    logic              i_clk = 1'b0;
    logic              i_rst_n;
    logic [DATA_W-1:0] i_data_a;
    logic [DATA_W-1:0] i_data_b;
    logic [OP_W-1:0]   i_inst;
    logic              o_busy;
    logic              o_valid;
    logic [DATA_W-1:0] o_data;

    logic [31:0] lfsr_state = 32'hcc7a_9697;
    int          prev_fails = 0;
    int          bad_tests  = 0;
    int          test_count = 0;

    alu_top u_dut (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_data_a (i_data_a),
        .i_data_b (i_data_b),
        .i_inst   (i_inst),
        .o_busy   (o_busy),
        .o_valid  (o_valid),
        .o_data   (o_data)
    );

    always #5 i_clk = ~i_clk;

    function automatic logic rand_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = {1'b0, lfsr_state[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
        return b;
    endfunction

    function automatic logic [DATA_W-1:0] rand_bits(input int n);
        logic [DATA_W-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[DATA_W-2:0], rand_bit()};
        end
        return v;
    endfunction

    // drive on the edge that opens a non-busy cycle
    task automatic issue(input logic [OP_W-1:0] op, input logic [DATA_W-1:0] a,
                         input logic [DATA_W-1:0] b);
        do begin
            @(negedge i_clk);
        end while (!o_busy);
        @(posedge i_clk);
        i_inst   <= op;
        i_data_a <= a;
        i_data_b <= b;
    endtask

    task automatic drain();
        do begin
            @(negedge i_clk);
        end while (!o_busy);
        do begin
            @(negedge i_clk);
        end while (!o_valid);
        @(negedge i_clk); // let the checking edge go by
    endtask

    task automatic end_test(input string name);
        int errs;
        drain();
        errs = u_dut.u_assertions.fail_count - prev_fails;
        prev_fails = u_dut.u_assertions.fail_count;
        test_count++;
        if (errs != 0) begin
            bad_tests++;
        end
        $display("%-18s %s, %0d assertion failures", name, (errs == 0) ? "ok" : "errors", errs);
    endtask

    initial begin
        i_rst_n  = 1'b1;
        i_data_a = '0;
        i_data_b = '0;
        i_inst   = '0;
        i_rst_n <= 1'b0; // falling edge at time 0 fires the async reset
        repeat (10) @(posedge i_clk);
        i_rst_n <= 1'b1;

        issue(OP_FXMAC, 16'h0c00, 16'h0400); // accumulator still 0 here
        repeat (RAND_OPS) issue(4'(rand_bits(4)), rand_bits(16), rand_bits(16));
        end_test("reset and pacing");

        issue(OP_FXADD, 16'h7fff, 16'h7fff);
        issue(OP_FXADD, 16'h8000, 16'h8000);
        issue(OP_FXSUB, 16'h7fff, 16'h8000);
        issue(OP_FXSUB, 16'h8000, 16'h7fff);
        repeat (RAND_OPS) issue(4'(rand_bits(1)), rand_bits(16), rand_bits(16));
        end_test("add and subtract");

        issue(OP_FXMUL, 16'h7fff, 16'h7fff);
        issue(OP_FXMUL, 16'h8000, 16'h8000);
        issue(OP_FXMUL, 16'h8000, 16'h7fff);
        issue(OP_FXMUL, 16'h1e00, 16'h1111); // rounds up past the maximum
        issue(OP_FXMUL, 16'h0001, 16'h0200);
        repeat (RAND_OPS) issue(OP_FXMUL, rand_bits(16), rand_bits(16));
        end_test("multiply");

        repeat (4) issue(OP_FXMAC, 16'h0400, 16'h0400); // +1.0 per step
        issue(OP_CLZ, 16'h0000, 16'h0000);
        issue(OP_FXMAC, 16'h0800, 16'hfc00);
        repeat (RAND_OPS) issue(rand_bits(1) ? OP_FXMAC : OP_FXADD, rand_bits(16), rand_bits(16));
        end_test("mac chain");

        issue(OP_CLZ, 16'h0000, rand_bits(16));
        issue(OP_CLZ, 16'hffff, rand_bits(16));
        issue(OP_LRCW, 16'h0000, rand_bits(16));
        issue(OP_LRCW, 16'hffff, rand_bits(16));
        repeat (RAND_OPS) issue(rand_bits(1) ? OP_CLZ : OP_LRCW,
                                rand_bits(16) >> rand_bits(4), rand_bits(16));
        end_test("clz and lrcw");

        for (int s = 0; s <= 8; s++) begin
            issue(OP_LFSR, rand_bits(16), DATA_W'(s));
        end
        issue(OP_LFSR, rand_bits(16), 16'h0009);
        issue(OP_LFSR, rand_bits(16), 16'hffff);
        issue(4'd4, rand_bits(16), rand_bits(16));
        for (int c = 8; c < 16; c++) begin
            issue(4'(c), rand_bits(16), rand_bits(16));
        end
        repeat (RAND_OPS) issue(OP_LFSR, rand_bits(16), rand_bits(4));
        end_test("lfsr and unused");

        $display("%0d tests run, %0d with errors, %0d assertion failures in total",
                 test_count, bad_tests, u_dut.u_assertions.fail_count);
        if (bad_tests == 0 && u_dut.u_assertions.fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG) @(posedge i_clk);
        $display("run timed out after %0d cycles before all tests finished", WATCHDOG);
        $display("test failed");
        $finish;
    end

endmodule

// ==== alu.f ====
common/alu_op_pkg.sv
common/alu_fx_pkg.sv
hw/alu_decode.sv
execute/alu_fx_arith.sv
execute/alu_bit_ops.sv
hw/alu_result.sv
hw/alu_top.sv
sim/alu_assertions.sv
sim/alu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= alu_tb
FLAGS     ?= -Wno-fatal

SRCS := $(shell cat alu.f)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) alu.f
	$(VERILATOR) --binary --assert $(FLAGS) --top-module $(TOP) -f alu.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
